//--- logic/sched_pkg.sv
/*
 * warp scheduler package
 * sizes, start PC, warp-control op enum and payload union,
 * branch, fetch request and divergence stack entry structs
 */
`default_nettype none

package sched_pkg;

    localparam int NUM_WARPS    = 4;
    localparam int NW_WIDTH     = 2;
    localparam int NUM_THREADS  = 4;
    localparam int PC_BITS      = 30;
    localparam int STACK_DEPTH  = 4;
    localparam int SP_WIDTH     = $clog2(STACK_DEPTH);
    localparam int NUM_BARRIERS = 4;
    localparam int BAR_ID_WIDTH = 2;
    localparam int PEND_WIDTH   = 8;

    // word address, byte 0x800
    localparam logic [PC_BITS-1:0] START_PC = 30'h0000_0200;

    // split is the widest member and sets the payload size
    localparam int CTL_PAYLOAD_BITS = 1 + 2 * NUM_THREADS + PC_BITS;

    typedef enum logic [2:0] {
        WCTL_TMC    = 3'd0,
        WCTL_WSPAWN = 3'd1,
        WCTL_SPLIT  = 3'd2,
        WCTL_JOIN   = 3'd3,
        WCTL_BAR    = 3'd4
    } warp_ctl_op_e;

    typedef struct packed {
        logic [CTL_PAYLOAD_BITS-NUM_THREADS-1:0] pad;
        logic [NUM_THREADS-1:0]                  tmask;
    } tmc_payload_t;

    typedef struct packed {
        logic [CTL_PAYLOAD_BITS-NUM_WARPS-PC_BITS-1:0] pad;
        logic [NUM_WARPS-1:0]                          wmask;
        logic [PC_BITS-1:0]                            pc;
    } wspawn_payload_t;

    typedef struct packed {
        logic                   is_dvg;
        logic [NUM_THREADS-1:0] then_tmask;
        logic [NUM_THREADS-1:0] else_tmask;
        logic [PC_BITS-1:0]     else_pc;
    } split_payload_t;

    typedef struct packed {
        logic [CTL_PAYLOAD_BITS-BAR_ID_WIDTH-NW_WIDTH-1:0] pad;
        logic [BAR_ID_WIDTH-1:0]                           id;
        // expected warp count minus one
        logic [NW_WIDTH-1:0]                               size_m1;
    } bar_payload_t;

    typedef struct packed {
        logic [CTL_PAYLOAD_BITS-1:0] pad;
    } join_payload_t;

    // one word, read according to the op
    typedef union packed {
        tmc_payload_t    tmc;
        wspawn_payload_t wspawn;
        split_payload_t  split;
        bar_payload_t    bar;
        join_payload_t   sjoin;
    } warp_ctl_payload_u;

    typedef struct packed {
        logic              valid;
        logic [NW_WIDTH-1:0] wid;
        warp_ctl_op_e      op;
        warp_ctl_payload_u payload;
    } warp_ctl_t;

    typedef struct packed {
        logic                valid;
        logic [NW_WIDTH-1:0] wid;
        logic                taken;
        logic [PC_BITS-1:0]  dest;
    } branch_t;

    typedef struct packed {
        logic [NW_WIDTH-1:0]    wid;
        logic [NUM_THREADS-1:0] tmask;
        logic [PC_BITS-1:0]     pc;
    } sched_req_t;

    typedef struct packed {
        logic                   is_else;
        logic [NUM_THREADS-1:0] tmask;
        logic [PC_BITS-1:0]     pc;
    } dvs_entry_t;

endpackage

`default_nettype wire

//--- logic/pending_counter.sv
/*
 * in-flight instruction counter with empty flag
 */
`timescale 1ns/1ps
`default_nettype none

module pending_counter (
    input  wire  clk,
    input  wire  reset,
    input  wire  incr,
    input  wire  decr,
    output logic empty
);
    import sched_pkg::*;

    logic [PEND_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (incr && !decr) begin
            count <= count + PEND_WIDTH'(1);
        end else if (decr && !incr) begin
            count <= count - PEND_WIDTH'(1);
        end
    end

    assign empty = (count == '0);

endmodule

`default_nettype wire

//--- logic/schedule_buffer.sv
/*
 * two-entry elastic buffer
 * registered output stage plus one skid entry
 */
`timescale 1ns/1ps
`default_nettype none

module schedule_buffer (
    input  wire                    clk,
    input  wire                    reset,
    input  sched_pkg::sched_req_t  in_data,
    input  wire                    in_valid,
    output logic                   in_ready,
    output sched_pkg::sched_req_t  out_data,
    output logic                   out_valid,
    input  wire                    out_ready
);
    import sched_pkg::*;

    sched_req_t skid_data;
    logic       skid_valid;
    logic       out_free;

    // output register can load this cycle
    assign out_free = out_ready || !out_valid;

    // only occupancy, no path from out_ready
    assign in_ready = !skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : in_data;
        end else if (in_valid && in_ready) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/split_join_stack.sv
/*
 * divergence stack, one per warp
 * split pushes, join pops; the popped entry is registered
 */
`timescale 1ns/1ps
`default_nettype none

module split_join_stack (
    input  wire                    clk,
    input  wire                    reset,
    input  sched_pkg::warp_ctl_t   warp_ctl,
    input  wire [sched_pkg::NUM_THREADS-1:0] cur_tmask,
    output logic                   join_valid,
    output logic [sched_pkg::NW_WIDTH-1:0] join_wid,
    output logic                   join_is_dvg,
    output sched_pkg::dvs_entry_t  join_entry
);
    import sched_pkg::*;

    dvs_entry_t stack_mem [NUM_WARPS][STACK_DEPTH];
    // clear marks a uniform-split marker
    logic       stack_dvg [NUM_WARPS][STACK_DEPTH];

    logic [NUM_WARPS-1:0][SP_WIDTH:0] stack_ptr;

    logic              split_req;
    logic              join_req;
    logic              is_dvg;
    logic [SP_WIDTH:0] cur_ptr;
    logic [SP_WIDTH-1:0] push_idx;
    logic [SP_WIDTH-1:0] push2_idx;
    logic [SP_WIDTH-1:0] pop_idx;
    dvs_entry_t        restore_entry;
    dvs_entry_t        else_entry;

    assign split_req = warp_ctl.valid && (warp_ctl.op == WCTL_SPLIT);
    assign join_req  = warp_ctl.valid && (warp_ctl.op == WCTL_JOIN);
    assign is_dvg    = warp_ctl.payload.split.is_dvg;

    assign cur_ptr   = stack_ptr[warp_ctl.wid];
    assign push_idx  = cur_ptr[SP_WIDTH-1:0];
    assign push2_idx = SP_WIDTH'(push_idx + SP_WIDTH'(1));
    assign pop_idx   = SP_WIDTH'(cur_ptr - (SP_WIDTH + 1)'(1));

    // restore entry goes below the else entry
    assign restore_entry.is_else = 1'b0;
    assign restore_entry.tmask   = cur_tmask;
    assign restore_entry.pc      = '0;

    assign else_entry.is_else = 1'b1;
    assign else_entry.tmask   = warp_ctl.payload.split.else_tmask;
    assign else_entry.pc      = warp_ctl.payload.split.else_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            stack_ptr  <= '0;
            join_valid <= 1'b0;
        end else begin
            join_valid <= join_req;
            if (split_req) begin
                stack_ptr[warp_ctl.wid] <= cur_ptr + (is_dvg ? (SP_WIDTH + 1)'(2)
                                                             : (SP_WIDTH + 1)'(1));
            end else if (join_req) begin
                stack_ptr[warp_ctl.wid] <= cur_ptr - (SP_WIDTH + 1)'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (split_req) begin
            stack_mem[warp_ctl.wid][push_idx] <= restore_entry;
            stack_dvg[warp_ctl.wid][push_idx] <= is_dvg;
            if (is_dvg) begin
                stack_mem[warp_ctl.wid][push2_idx] <= else_entry;
                stack_dvg[warp_ctl.wid][push2_idx] <= 1'b1;
            end
        end
        if (join_req) begin
            join_wid    <= warp_ctl.wid;
            join_entry  <= stack_mem[warp_ctl.wid][pop_idx];
            join_is_dvg <= stack_dvg[warp_ctl.wid][pop_idx];
        end
    end

endmodule

`default_nettype wire

//--- logic/barrier_unit.sv
/*
 * barrier unit
 * per-id arrival masks, registered release mask
 */
`timescale 1ns/1ps
`default_nettype none

module barrier_unit (
    input  wire                  clk,
    input  wire                  reset,
    input  sched_pkg::warp_ctl_t warp_ctl,
    input  wire [sched_pkg::NUM_WARPS-1:0] active_warps,
    output logic                 unlock_valid,
    output logic [sched_pkg::NUM_WARPS-1:0] unlock_mask
);
    import sched_pkg::*;

    logic [NUM_BARRIERS-1:0][NUM_WARPS-1:0] arrived;
    logic                    bar_req;
    logic [BAR_ID_WIDTH-1:0] bar_id;
    logic [NUM_WARPS-1:0]    next_mask;
    logic [NW_WIDTH:0]       next_cnt;
    logic                    release_bar;

    assign bar_req = warp_ctl.valid && (warp_ctl.op == WCTL_BAR);
    assign bar_id  = warp_ctl.payload.bar.id;

    // exited warps fall out of the count
    assign next_mask = (arrived[bar_id] | (NUM_WARPS'(1) << warp_ctl.wid)) & active_warps;

    always_comb begin
        next_cnt = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            next_cnt = next_cnt + (NW_WIDTH + 1)'(next_mask[i]);
        end
    end

    assign release_bar = bar_req
        && (next_cnt == (NW_WIDTH + 1)'(warp_ctl.payload.bar.size_m1) + (NW_WIDTH + 1)'(1));

    always_ff @(posedge clk) begin
        if (reset) begin
            arrived      <= '0;
            unlock_valid <= 1'b0;
            unlock_mask  <= '0;
        end else begin
            for (int b = 0; b < NUM_BARRIERS; b++) begin
                arrived[b] <= arrived[b] & active_warps;
            end
            unlock_valid <= release_bar;
            if (bar_req) begin
                // last arrival empties the barrier
                arrived[bar_id] <= release_bar ? '0 : next_mask;
            end
            if (release_bar) begin
                unlock_mask <= next_mask;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/warp_scheduler.sv
/*
 * warp scheduler top
 * per-warp active/stall/mask/PC state, warp-control handling,
 * lowest-ready warp selection and the busy flag
 */
`timescale 1ns/1ps
`default_nettype none

module warp_scheduler (
    input  wire                  clk,
    input  wire                  reset,
    input  sched_pkg::warp_ctl_t warp_ctl,
    input  sched_pkg::branch_t   branch,
    input  wire                  decode_unlock,
    input  wire [sched_pkg::NW_WIDTH-1:0] decode_wid,
    input  wire                  issue_fire,
    input  wire                  commit_fire,
    input  wire                  sched_ready,
    output sched_pkg::sched_req_t sched_out,
    output logic                 sched_valid,
    output logic                 busy
);
    import sched_pkg::*;

    logic [NUM_WARPS-1:0] active_warps, active_warps_n;
    logic [NUM_WARPS-1:0] stalled_warps, stalled_warps_n;
    logic [NUM_WARPS-1:0][NUM_THREADS-1:0] thread_masks, thread_masks_n;
    logic [NUM_WARPS-1:0][PC_BITS-1:0]     warp_pcs, warp_pcs_n;

    // pending wspawn, applied once a single warp is left
    logic                 wspawn_valid;
    logic [NUM_WARPS-1:0] wspawn_wmask;
    logic [PC_BITS-1:0]   wspawn_pc;
    logic [NW_WIDTH-1:0]  wspawn_wid;
    logic                 is_single_warp;
    logic [NW_WIDTH:0]    active_cnt;

    logic                 join_valid;
    logic [NW_WIDTH-1:0]  join_wid;
    logic                 join_is_dvg;
    dvs_entry_t           join_entry;

    logic                 bar_unlock_valid;
    logic [NUM_WARPS-1:0] bar_unlock_mask;

    logic [NUM_WARPS-1:0] ready_warps;
    logic                 sel_valid;
    logic [NW_WIDTH-1:0]  sel_wid;
    sched_req_t           sel_req;
    logic                 sel_ready;
    logic                 sched_fire;
    logic                 pend_empty;

    logic tmc_req, wspawn_req, split_req;

    assign tmc_req    = warp_ctl.valid && (warp_ctl.op == WCTL_TMC);
    assign wspawn_req = warp_ctl.valid && (warp_ctl.op == WCTL_WSPAWN);
    assign split_req  = warp_ctl.valid && (warp_ctl.op == WCTL_SPLIT);

    always_comb begin
        active_cnt = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            active_cnt = active_cnt + (NW_WIDTH + 1)'(active_warps[i]);
        end
    end

    always_comb begin
        active_warps_n  = active_warps;
        stalled_warps_n = stalled_warps;
        thread_masks_n  = thread_masks;
        warp_pcs_n      = warp_pcs;

        if (decode_unlock) begin
            stalled_warps_n[decode_wid] = 1'b0;
        end

        if (wspawn_valid && is_single_warp) begin
            active_warps_n = active_warps_n | wspawn_wmask;
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (wspawn_wmask[i]) begin
                    thread_masks_n[i] = NUM_THREADS'(1);
                    warp_pcs_n[i]     = wspawn_pc;
                end
            end
            stalled_warps_n[wspawn_wid] = 1'b0;
        end

        // a zero mask retires the warp
        if (tmc_req) begin
            active_warps_n[warp_ctl.wid]  = (warp_ctl.payload.tmc.tmask != '0);
            thread_masks_n[warp_ctl.wid]  = warp_ctl.payload.tmc.tmask;
            stalled_warps_n[warp_ctl.wid] = 1'b0;
        end

        if (split_req) begin
            if (warp_ctl.payload.split.is_dvg) begin
                thread_masks_n[warp_ctl.wid] = warp_ctl.payload.split.then_tmask;
            end
            stalled_warps_n[warp_ctl.wid] = 1'b0;
        end

        // else entry redirects the PC, restore entry only the mask
        if (join_valid) begin
            if (join_is_dvg) begin
                if (join_entry.is_else) begin
                    warp_pcs_n[join_wid] = join_entry.pc;
                end
                thread_masks_n[join_wid] = join_entry.tmask;
            end
            stalled_warps_n[join_wid] = 1'b0;
        end

        if (bar_unlock_valid) begin
            stalled_warps_n = stalled_warps_n & ~bar_unlock_mask;
        end

        if (branch.valid) begin
            if (branch.taken) begin
                warp_pcs_n[branch.wid] = branch.dest;
            end
            stalled_warps_n[branch.wid] = 1'b0;
        end

        // hold the warp until the pipeline answers
        if (sched_fire) begin
            stalled_warps_n[sel_wid] = 1'b1;
            warp_pcs_n[sel_wid]      = sel_req.pc + PC_BITS'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_warps    <= NUM_WARPS'(1);
            stalled_warps   <= '0;
            thread_masks    <= '0;
            thread_masks[0] <= NUM_THREADS'(1);
            warp_pcs        <= '0;
            warp_pcs[0]     <= START_PC;
            wspawn_valid    <= 1'b0;
            is_single_warp  <= 1'b1;
            busy            <= 1'b0;
        end else begin
            active_warps   <= active_warps_n;
            stalled_warps  <= stalled_warps_n;
            thread_masks   <= thread_masks_n;
            warp_pcs       <= warp_pcs_n;
            is_single_warp <= (active_cnt == (NW_WIDTH + 1)'(1));
            busy           <= (active_warps != '0) || !pend_empty;
            if (wspawn_req) begin
                wspawn_valid <= 1'b1;
            end else if (wspawn_valid && is_single_warp) begin
                wspawn_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wspawn_req) begin
            wspawn_wmask <= warp_ctl.payload.wspawn.wmask;
            wspawn_pc    <= warp_ctl.payload.wspawn.pc;
            wspawn_wid   <= warp_ctl.wid;
        end
    end

    // lowest ready warp wins
    assign ready_warps = active_warps & ~stalled_warps;
    assign sel_valid   = (ready_warps != '0);

    always_comb begin
        sel_wid = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                sel_wid = NW_WIDTH'(i);
            end
        end
    end

    assign sel_req.wid   = sel_wid;
    assign sel_req.tmask = thread_masks[sel_wid];
    assign sel_req.pc    = warp_pcs[sel_wid];
    assign sched_fire    = sel_valid && sel_ready;

    barrier_unit bar_unit_i (
        .clk          (clk),
        .reset        (reset),
        .warp_ctl     (warp_ctl),
        .active_warps (active_warps),
        .unlock_valid (bar_unlock_valid),
        .unlock_mask  (bar_unlock_mask)
    );

    split_join_stack split_join_i (
        .clk         (clk),
        .reset       (reset),
        .warp_ctl    (warp_ctl),
        .cur_tmask   (thread_masks[warp_ctl.wid]),
        .join_valid  (join_valid),
        .join_wid    (join_wid),
        .join_is_dvg (join_is_dvg),
        .join_entry  (join_entry)
    );

    schedule_buffer out_buf_i (
        .clk       (clk),
        .reset     (reset),
        .in_data   (sel_req),
        .in_valid  (sel_valid),
        .in_ready  (sel_ready),
        .out_data  (sched_out),
        .out_valid (sched_valid),
        .out_ready (sched_ready)
    );

    pending_counter pend_cnt_i (
        .clk   (clk),
        .reset (reset),
        .incr  (issue_fire),
        .decr  (commit_fire),
        .empty (pend_empty)
    );

endmodule

`default_nettype wire

//--- testbench/sched_model.svh
/*
 * reference model of the warp scheduler state
 * per-warp active, waiting, mask and PC, divergence stacks,
 * the open barrier and the pending count, with update functions
 */
`ifndef SCHED_MODEL_SVH
`define SCHED_MODEL_SVH

logic [NUM_WARPS-1:0]                  m_active;
// warp has an accepted request without a response yet
logic [NUM_WARPS-1:0]                  m_waiting;
logic [NUM_WARPS-1:0][NUM_THREADS-1:0] m_tmask;
logic [NUM_WARPS-1:0][PC_BITS-1:0]     m_pc;
dvs_entry_t                            m_stack [NUM_WARPS][STACK_DEPTH];
logic                                  m_stack_dvg [NUM_WARPS][STACK_DEPTH];
int                                    m_depth [NUM_WARPS];
// warps parked at the one open barrier
logic [NUM_WARPS-1:0]                  m_bar_mask;
int                                    m_bar_size;
logic [BAR_ID_WIDTH-1:0]               m_bar_id;
int                                    m_pending;

function automatic void reset_model();
    m_active   = NUM_WARPS'(1);
    m_waiting  = '0;
    m_tmask    = '0;
    m_tmask[0] = NUM_THREADS'(1);
    m_pc       = '0;
    m_pc[0]    = START_PC;
    m_bar_mask = '0;
    m_bar_size = 0;
    m_bar_id   = '0;
    m_pending  = 0;
    for (int w = 0; w < NUM_WARPS; w++) begin
        m_depth[w] = 0;
    end
endfunction

function automatic int active_count();
    int n = 0;
    for (int i = 0; i < NUM_WARPS; i++) begin
        n = n + int'(m_active[i]);
    end
    return n;
endfunction

function automatic void advance_pc(logic [NW_WIDTH-1:0] wid);
    m_waiting[wid] = 1'b1;
    m_pc[wid]      = m_pc[wid] + PC_BITS'(1);
endfunction

function automatic void set_tmask(logic [NW_WIDTH-1:0] wid, logic [NUM_THREADS-1:0] mask);
    m_active[wid]  = (mask != '0);
    m_tmask[wid]   = mask;
    m_waiting[wid] = 1'b0;
endfunction

function automatic void take_branch(logic [NW_WIDTH-1:0] wid, logic taken,
                                    logic [PC_BITS-1:0] dest);
    if (taken) begin
        m_pc[wid] = dest;
    end
    m_waiting[wid] = 1'b0;
endfunction

function automatic void spawn_warps(logic [NW_WIDTH-1:0] wid, logic [NUM_WARPS-1:0] wmask,
                                    logic [PC_BITS-1:0] pc);
    for (int i = 0; i < NUM_WARPS; i++) begin
        if (wmask[i]) begin
            m_active[i] = 1'b1;
            m_tmask[i]  = NUM_THREADS'(1);
            m_pc[i]     = pc;
        end
    end
    m_waiting[wid] = 1'b0;
endfunction

function automatic void push_split(logic [NW_WIDTH-1:0] wid, logic is_dvg,
                                   logic [NUM_THREADS-1:0] then_mask,
                                   logic [NUM_THREADS-1:0] else_mask,
                                   logic [PC_BITS-1:0] else_pc);
    logic [SP_WIDTH-1:0] idx;
    idx = SP_WIDTH'(m_depth[wid]);
    // restore entry below, else entry on top
    m_stack[wid][idx].is_else = 1'b0;
    m_stack[wid][idx].tmask   = m_tmask[wid];
    m_stack[wid][idx].pc      = '0;
    m_stack_dvg[wid][idx]     = is_dvg;
    if (is_dvg) begin
        idx = SP_WIDTH'(m_depth[wid] + 1);
        m_stack[wid][idx].is_else = 1'b1;
        m_stack[wid][idx].tmask   = else_mask;
        m_stack[wid][idx].pc      = else_pc;
        m_stack_dvg[wid][idx]     = 1'b1;
        m_tmask[wid]              = then_mask;
        m_depth[wid]              = m_depth[wid] + 2;
    end else begin
        m_depth[wid] = m_depth[wid] + 1;
    end
    m_waiting[wid] = 1'b0;
endfunction

function automatic void pop_join(logic [NW_WIDTH-1:0] wid);
    logic [SP_WIDTH-1:0] idx;
    dvs_entry_t          top;
    idx = SP_WIDTH'(m_depth[wid] - 1);
    top = m_stack[wid][idx];
    // a uniform marker leaves the warp alone
    if (m_stack_dvg[wid][idx]) begin
        if (top.is_else) begin
            m_pc[wid] = top.pc;
        end
        m_tmask[wid] = top.tmask;
    end
    m_depth[wid]   = m_depth[wid] - 1;
    m_waiting[wid] = 1'b0;
endfunction

function automatic void arrive_barrier(logic [NW_WIDTH-1:0] wid);
    m_bar_mask[wid] = 1'b1;
    if ($countones(m_bar_mask) == m_bar_size) begin
        m_waiting  = m_waiting & ~m_bar_mask;
        m_bar_mask = '0;
    end
endfunction

`endif

//--- testbench/tb_warp_scheduler.sv
/*
 * testbench for the warp scheduler
 * random pipeline responses checked against a reference model,
 * back-pressure hold, busy tracking and a cycle timeout
 */
`timescale 1ns/1ps
`default_nettype none

module tb_warp_scheduler;
    import sched_pkg::*;

    localparam int NUM_RESPONSES = 2000;
    localparam int MAX_CYCLES    = NUM_RESPONSES * 40 + 500;

    localparam int K_UNLOCK = 0;
    localparam int K_BRANCH = 1;
    localparam int K_TMC    = 2;
    localparam int K_WSPAWN = 3;
    localparam int K_SPLIT  = 4;
    localparam int K_JOIN   = 5;
    localparam int K_BAR    = 6;
    localparam int K_RETIRE = 7;

    logic                clk;
    logic                reset;
    warp_ctl_t           warp_ctl;
    branch_t             branch;
    logic                decode_unlock;
    logic [NW_WIDTH-1:0] decode_wid;
    logic                issue_fire;
    logic                commit_fire;
    logic                sched_ready;
    sched_req_t          sched_out;
    logic                sched_valid;
    logic                busy;

    `include "sched_model.svh"

    sched_req_t resp_queue[$];
    int         responses_sent;
    int         live_cycles;
    int         cycles = 0;
    logic       final_phase;
    logic       busy_hist1;
    logic       busy_hist2;
    logic       prev_stall;
    sched_req_t prev_out;

    warp_scheduler dut_i (
        .clk           (clk),
        .reset         (reset),
        .warp_ctl      (warp_ctl),
        .branch        (branch),
        .decode_unlock (decode_unlock),
        .decode_wid    (decode_wid),
        .issue_fire    (issue_fire),
        .commit_fire   (commit_fire),
        .sched_ready   (sched_ready),
        .sched_out     (sched_out),
        .sched_valid   (sched_valid),
        .busy          (busy)
    );

    always #50 clk = ~clk;

    task automatic report_failure(string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles, responses stopped", cycles));
        end
    end

    task automatic check_req(string name, sched_req_t got, sched_req_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_busy(logic got, logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERROR busy got %h expected %h", got, exp));
        end
    endtask

    task automatic idle_inputs();
        warp_ctl      = '0;
        branch        = '0;
        decode_unlock = 1'b0;
        decode_wid    = '0;
        issue_fire    = 1'b0;
        commit_fire   = 1'b0;
    endtask

    function automatic int pick_kind(logic [NW_WIDTH-1:0] wid);
        int pick;
        int kind;
        pick = int'($urandom_range(99, 0));
        if (m_bar_mask != '0) begin
            return K_BAR;
        end
        if (final_phase) begin
            return K_RETIRE;
        end
        if (pick < 30) kind = K_UNLOCK;
        else if (pick < 50) kind = K_BRANCH;
        else if (pick < 60) kind = K_TMC;
        else if (pick < 68) kind = K_WSPAWN;
        else if (pick < 80) kind = K_SPLIT;
        else if (pick < 92) kind = K_JOIN;
        else kind = K_BAR;
        // fall back where the state does not allow the pick
        if (kind == K_WSPAWN && active_count() != 1) kind = K_UNLOCK;
        if (kind == K_SPLIT && m_depth[wid] + 2 > STACK_DEPTH) kind = K_JOIN;
        if (kind == K_JOIN && m_depth[wid] == 0) kind = K_UNLOCK;
        return kind;
    endfunction

    task automatic drive_response(sched_req_t req);
        logic [NW_WIDTH-1:0]    wid;
        logic [NUM_THREADS-1:0] mask;
        logic [NUM_WARPS-1:0]   wmask;
        int                     kind;
        wid  = req.wid;
        kind = pick_kind(wid);
        warp_ctl.wid = wid;
        case (kind)
            K_UNLOCK: begin
                decode_unlock  = 1'b1;
                decode_wid     = wid;
                issue_fire     = 1'b1;
                m_pending      = m_pending + 1;
                m_waiting[wid] = 1'b0;
            end
            K_BRANCH: begin
                branch.valid = 1'b1;
                branch.wid   = wid;
                branch.taken = 1'($urandom_range(1, 0));
                branch.dest  = PC_BITS'($urandom);
                take_branch(wid, branch.taken, branch.dest);
            end
            K_TMC, K_RETIRE: begin
                mask = NUM_THREADS'($urandom_range(15, 1));
                if (kind == K_RETIRE || (active_count() > 1 && $urandom_range(3, 0) == 0)) begin
                    mask = '0;
                end
                warp_ctl.valid             = 1'b1;
                warp_ctl.op                = WCTL_TMC;
                warp_ctl.payload.tmc.tmask = mask;
                set_tmask(wid, mask);
            end
            K_WSPAWN: begin
                wmask = NUM_WARPS'($urandom) & ~(NUM_WARPS'(1) << wid);
                warp_ctl.valid                = 1'b1;
                warp_ctl.op                   = WCTL_WSPAWN;
                warp_ctl.payload.wspawn.wmask = wmask;
                warp_ctl.payload.wspawn.pc    = PC_BITS'($urandom);
                spawn_warps(wid, wmask, warp_ctl.payload.wspawn.pc);
            end
            K_SPLIT: begin
                warp_ctl.valid                    = 1'b1;
                warp_ctl.op                       = WCTL_SPLIT;
                warp_ctl.payload.split.is_dvg     = 1'($urandom_range(1, 0));
                warp_ctl.payload.split.then_tmask = NUM_THREADS'($urandom_range(15, 1));
                warp_ctl.payload.split.else_tmask = NUM_THREADS'($urandom_range(15, 1));
                warp_ctl.payload.split.else_pc    = PC_BITS'($urandom);
                push_split(wid, warp_ctl.payload.split.is_dvg,
                           warp_ctl.payload.split.then_tmask,
                           warp_ctl.payload.split.else_tmask,
                           warp_ctl.payload.split.else_pc);
            end
            K_JOIN: begin
                warp_ctl.valid = 1'b1;
                warp_ctl.op    = WCTL_JOIN;
                pop_join(wid);
            end
            default: begin
                // first arrival opens a barrier sized to the active warps
                if (m_bar_mask == '0) begin
                    m_bar_id   = BAR_ID_WIDTH'($urandom);
                    m_bar_size = active_count();
                end
                warp_ctl.valid               = 1'b1;
                warp_ctl.op                  = WCTL_BAR;
                warp_ctl.payload.bar.id      = m_bar_id;
                warp_ctl.payload.bar.size_m1 = NW_WIDTH'(m_bar_size - 1);
                arrive_barrier(wid);
            end
        endcase
    endtask

    task automatic drive_cycle();
        idle_inputs();
        sched_ready = ($urandom_range(3, 0) != 0);
        if (m_pending > 0 && $urandom_range(1, 0) == 1) begin
            commit_fire = 1'b1;
            m_pending   = m_pending - 1;
        end
        if (resp_queue.size() > 0 && $urandom_range(4, 0) < 3) begin
            drive_response(resp_queue.pop_front());
            responses_sent = responses_sent + 1;
            if (responses_sent >= NUM_RESPONSES) begin
                final_phase = 1'b1;
            end
        end
    endtask

    task automatic sample_outputs();
        sched_req_t          exp;
        logic [NW_WIDTH-1:0] wid;
        // busy lags the driven responses by two edges
        if (live_cycles >= 2) begin
            check_busy(busy, busy_hist2);
        end
        live_cycles = live_cycles + 1;
        busy_hist2  = busy_hist1;
        busy_hist1  = (m_active != '0) || (m_pending != 0);
        if (prev_stall) begin
            if (!sched_valid) begin
                report_failure("sched_valid dropped while sched_ready was low");
            end
            check_req("sched_out", sched_out, prev_out);
        end
        prev_stall = sched_valid && !sched_ready;
        prev_out   = sched_out;
        if (sched_valid && sched_ready) begin
            wid = sched_out.wid;
            if (!m_active[wid]) begin
                report_failure($sformatf("warp %0d issued while it is not active", wid));
            end
            if (m_waiting[wid]) begin
                report_failure($sformatf("warp %0d issued again before its response", wid));
            end
            exp.wid   = wid;
            exp.tmask = m_tmask[wid];
            exp.pc    = m_pc[wid];
            check_req("sched_out", sched_out, exp);
            advance_pc(wid);
            resp_queue.push_back(sched_out);
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #1;
        drive_cycle();
        @(negedge clk);
        sample_outputs();
    endtask

    function automatic logic run_done();
        return final_phase && (m_active == '0) && (m_pending == 0)
            && (resp_queue.size() == 0) && !busy_hist1 && !busy_hist2;
    endfunction

    initial begin
        void'($urandom(32'hf9a4_524f));
        clk            = 1'b0;
        reset          = 1'b1;
        sched_ready    = 1'b0;
        idle_inputs();
        reset_model();
        final_phase    = 1'b0;
        responses_sent = 0;
        live_cycles    = 0;
        busy_hist1     = 1'b0;
        busy_hist2     = 1'b0;
        prev_stall     = 1'b0;
        prev_out       = '0;
        repeat (5) @(posedge clk);
        #1 reset = 1'b0;
        while (!run_done()) begin
            run_cycle();
        end
        // one more sample so busy is compared with the idle model
        run_cycle();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
logic/sched_pkg.sv
logic/pending_counter.sv
logic/schedule_buffer.sv
logic/split_join_stack.sv
logic/barrier_unit.sv
logic/warp_scheduler.sv
testbench/tb_warp_scheduler.sv
+incdir+testbench

//--- run.sh
#!/bin/sh
# build and run the warp scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module tb_warp_scheduler \
    --Mdir obj_dir -o tb_warp_scheduler
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/tb_warp_scheduler
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0
